//--- axi_adapter_pkg.sv
// shared widths and channel structs for the cache-to-bus adapter, imported by RTL and testbench
package axi_adapter_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int unsigned ADDR_WIDTH      = 32;
  localparam int unsigned DATA_WIDTH      = 64;
  localparam int unsigned STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int unsigned ID_WIDTH        = 4;
  // words are 8 bytes, so the word select starts at bit 3
  localparam int unsigned WORD_OFFSET_LSB = 3;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;
  typedef logic [ID_WIDTH-1:0]   id_t;

  // beat size code, 0 to 3 for 1, 2, 4 or 8 bytes
  typedef logic [2:0] size_t;

  // --------------------
  // bus channels
  // --------------------
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    size_t      size;
    id_t        id;
  } aw_chan_t;

  typedef struct packed {
    word_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  // outgoing write beat before the last flag is attached
  typedef struct packed {
    word_t data;
    strb_t strb;
  } wbeat_t;

  typedef struct packed {
    id_t id;
  } b_chan_t;

  // read address has the same fields as write address
  typedef aw_chan_t ar_chan_t;

  typedef struct packed {
    word_t data;
    id_t   id;
    logic  last;
  } r_chan_t;

  // adapter to bus
  typedef struct packed {
    logic     aw_valid;
    aw_chan_t aw;
    logic     w_valid;
    w_chan_t  w;
    logic     b_ready;
    logic     ar_valid;
    ar_chan_t ar;
    logic     r_ready;
  } axi_req_t;

  // bus to adapter
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    b_valid;
    b_chan_t b;
    logic    ar_ready;
    logic    r_valid;
    r_chan_t r;
  } axi_rsp_t;

endpackage

//--- beat_counter.sv
// burst beat counter, cleared by the adapter FSM and stepped once per data handshake
`timescale 1ns/1ns

module beat_counter #(
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,
  input  logic                          line_i,
  input  logic                          step_i,
  output logic [$clog2(LINE_WORDS)-1:0] beat_o,
  output logic                          last_o
);

  localparam int unsigned IDX_W = $clog2(LINE_WORDS);
  localparam logic [IDX_W-1:0] LINE_LAST = IDX_W'(LINE_WORDS - 1);

  logic [IDX_W-1:0] beat_q;
  logic [IDX_W-1:0] final_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_q  <= '0;
      final_q <= '0;
    end else if (start_i) begin
      // a beat taken in the start cycle already counts
      beat_q  <= step_i ? IDX_W'(1) : '0;
      final_q <= line_i ? LINE_LAST : '0;
    end else if (step_i) begin
      beat_q <= beat_q + IDX_W'(1);
    end
  end

  assign beat_o = beat_q;
  assign last_o = (beat_q == final_q);

endmodule

//--- line_buffer.sv
// line data path, picks write beats from the client line and assembles read beats into a line
`timescale 1ns/1ns

module line_buffer
  import axi_adapter_pkg::*;
#(
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  word_t [LINE_WORDS-1:0]        wdata_i,
  input  strb_t [LINE_WORDS-1:0]        be_i,
  input  logic [$clog2(LINE_WORDS)-1:0] beat_i,
  output wbeat_t                        wbeat_o,
  input  logic                          rd_start_i,
  input  logic                          line_i,
  input  logic [$clog2(LINE_WORDS)-1:0] offset_i,
  input  r_chan_t                       r_i,
  input  logic                          r_take_i,
  output word_t [LINE_WORDS-1:0]        line_o,
  output id_t                           id_o,
  output word_t                         crit_o,
  output logic                          crit_valid_o
);

  localparam int unsigned IDX_W = $clog2(LINE_WORDS);

  logic [IDX_W-1:0]       offset_q;
  logic                   line_q;
  word_t [LINE_WORDS-1:0] data_q;
  id_t                    id_q;

  // --------------------
  // write side
  // --------------------
  assign wbeat_o.data = wdata_i[beat_i];
  assign wbeat_o.strb = be_i[beat_i];

  // --------------------
  // read side
  // --------------------

  // offset and line flag are sampled at the ar handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= '0;
      line_q   <= 1'b0;
    end else if (rd_start_i) begin
      offset_q <= offset_i;
      line_q   <= line_i;
    end
  end

  // a single read lands in word 0 since its beat index is 0
  always_ff @(posedge clk_i) begin
    if (r_take_i) begin
      data_q[beat_i] <= r_i.data;
      id_q           <= r_i.id;
    end
  end

  assign line_o = data_q;
  assign id_o   = id_q;

  // critical word goes straight from the bus beat
  assign crit_o       = r_i.data;
  assign crit_valid_o = r_take_i && line_q && (beat_i == offset_q);

endmodule

//--- adapter_fsm.sv
// control FSM of the adapter, runs the bus handshakes and the client grant and completion
`timescale 1ns/1ns

module adapter_fsm
  import axi_adapter_pkg::*;
#(
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  // client side
  input  logic     req_i,
  input  logic     we_i,
  input  logic     line_i,
  input  addr_t    addr_i,
  input  size_t    size_i,
  input  id_t      id_i,
  output logic     gnt_o,
  output logic     busy_o,
  output logic     valid_o,
  output id_t      bid_o,
  output logic     id_sel_o,
  // bus side
  input  axi_rsp_t axi_rsp_i,
  output axi_req_t axi_req_o,
  // data path and counter
  input  wbeat_t   wbeat_i,
  output logic     cnt_start_o,
  output logic     cnt_step_o,
  input  logic     last_i,
  output logic     rd_start_o,
  output logic     r_take_o
);

  localparam int unsigned IDX_W    = $clog2(LINE_WORDS);
  localparam int unsigned LINE_LSB = WORD_OFFSET_LSB + IDX_W;
  localparam logic [7:0]  LEN_LINE = 8'(LINE_WORDS - 1);
  localparam addr_t       LINE_MASK = ~addr_t'((64'd1 << LINE_LSB) - 64'd1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_AW,        // single write, data gone, aw pending
    S_W_AW,      // line write, beats and aw both pending
    S_AW_BURST,  // line write, all beats gone, aw pending
    S_W,         // aw done, sending beats
    S_B,
    S_R,
    S_RC
  } state_e;

  state_e state_q, state_d;

  logic [7:0] len;

  assign len = line_i ? LEN_LINE : 8'd0;

  always_comb begin
    axi_req_o = '0;

    // line writes start at the line-aligned address
    axi_req_o.aw.addr = line_i ? (addr_i & LINE_MASK) : addr_i;
    axi_req_o.aw.len  = len;
    axi_req_o.aw.size = size_i;
    axi_req_o.aw.id   = id_i;

    axi_req_o.w.data = wbeat_i.data;
    axi_req_o.w.strb = wbeat_i.strb;
    axi_req_o.w.last = last_i;

    // line reads start at the line-aligned address
    axi_req_o.ar.addr = line_i ? (addr_i & LINE_MASK) : addr_i;
    axi_req_o.ar.len  = len;
    axi_req_o.ar.size = size_i;
    axi_req_o.ar.id   = id_i;

    gnt_o      = 1'b0;
    valid_o    = 1'b0;
    cnt_step_o = 1'b0;
    rd_start_o = 1'b0;
    r_take_o   = 1'b0;
    state_d    = state_q;

    case (state_q)
      S_IDLE: begin
        if (req_i && we_i) begin
          axi_req_o.aw_valid = 1'b1;
          axi_req_o.w_valid  = 1'b1;
          // counter final index is not loaded yet in this cycle
          axi_req_o.w.last   = ~line_i;
          cnt_step_o         = axi_rsp_i.w_ready;
          if (!line_i) begin
            gnt_o = axi_rsp_i.aw_ready & axi_rsp_i.w_ready;
            case ({axi_rsp_i.aw_ready, axi_rsp_i.w_ready})
              2'b11:   state_d = S_B;
              2'b10:   state_d = S_W;
              2'b01:   state_d = S_AW;
              default: state_d = S_IDLE;
            endcase
          end else begin
            case ({axi_rsp_i.aw_ready, axi_rsp_i.w_ready})
              2'b11,
              2'b10:   state_d = S_W;
              2'b01:   state_d = S_W_AW;
              default: state_d = S_IDLE;
            endcase
          end
        end else if (req_i) begin
          axi_req_o.ar_valid = 1'b1;
          gnt_o              = axi_rsp_i.ar_ready;
          rd_start_o         = axi_rsp_i.ar_ready;
          if (axi_rsp_i.ar_ready) begin
            state_d = S_R;
          end
        end
      end

      S_W_AW: begin
        axi_req_o.aw_valid = 1'b1;
        axi_req_o.w_valid  = 1'b1;
        cnt_step_o         = axi_rsp_i.w_ready;
        case ({axi_rsp_i.aw_ready, axi_rsp_i.w_ready})
          2'b11: begin
            gnt_o   = last_i;
            state_d = last_i ? S_B : S_W;
          end
          2'b10:   state_d = S_W;
          2'b01:   state_d = last_i ? S_AW_BURST : S_W_AW;
          default: state_d = S_W_AW;
        endcase
      end

      S_AW, S_AW_BURST: begin
        axi_req_o.aw_valid = 1'b1;
        if (axi_rsp_i.aw_ready) begin
          gnt_o   = 1'b1;
          state_d = S_B;
        end
      end

      S_W: begin
        axi_req_o.w_valid = 1'b1;
        cnt_step_o        = axi_rsp_i.w_ready;
        if (axi_rsp_i.w_ready && last_i) begin
          gnt_o   = 1'b1;
          state_d = S_B;
        end
      end

      S_B: begin
        // ready only while the response is offered
        axi_req_o.b_ready = axi_rsp_i.b_valid;
        if (axi_rsp_i.b_valid) begin
          valid_o = 1'b1;
          state_d = S_IDLE;
        end
      end

      S_R: begin
        axi_req_o.r_ready = 1'b1;
        if (axi_rsp_i.r_valid) begin
          r_take_o   = 1'b1;
          cnt_step_o = 1'b1;
          if (axi_rsp_i.r.last) begin
            state_d = S_RC;
          end
        end
      end

      S_RC: begin
        valid_o = 1'b1;
        state_d = S_IDLE;
      end

      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // keeps the beat index at 0 in every idle cycle
  assign cnt_start_o = (state_q == S_IDLE) || (state_d == S_IDLE);

  assign busy_o   = (state_q != S_IDLE);
  assign bid_o    = axi_rsp_i.b.id;
  assign id_sel_o = (state_q == S_RC);

endmodule

//--- axi_adapter_top.sv
// top level of the cache-to-bus adapter, connects the FSM, beat counter and line buffer
`timescale 1ns/1ns

module axi_adapter_top
  import axi_adapter_pkg::*;
#(
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // client request
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic                   line_i,
  input  addr_t                  addr_i,
  input  size_t                  size_i,
  input  id_t                    id_i,
  input  word_t [LINE_WORDS-1:0] wdata_i,
  input  strb_t [LINE_WORDS-1:0] be_i,
  // client response
  output logic                   gnt_o,
  output logic                   busy_o,
  output logic                   valid_o,
  output word_t [LINE_WORDS-1:0] rdata_o,
  output id_t                    id_o,
  output word_t                  crit_o,
  output logic                   crit_valid_o,
  // bus
  output axi_req_t               axi_req_o,
  input  axi_rsp_t               axi_rsp_i
);

  localparam int unsigned IDX_W = $clog2(LINE_WORDS);

  logic [IDX_W-1:0] beat;
  logic             cnt_last;
  logic             cnt_start;
  logic             cnt_step;
  logic             rd_start;
  logic             r_take;
  logic             id_sel;
  wbeat_t           wbeat;
  id_t              bid;
  id_t              rid;

  adapter_fsm #(
    .LINE_WORDS (LINE_WORDS)
  ) u_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .we_i        (we_i),
    .line_i      (line_i),
    .addr_i      (addr_i),
    .size_i      (size_i),
    .id_i        (id_i),
    .gnt_o       (gnt_o),
    .busy_o      (busy_o),
    .valid_o     (valid_o),
    .bid_o       (bid),
    .id_sel_o    (id_sel),
    .axi_rsp_i   (axi_rsp_i),
    .axi_req_o   (axi_req_o),
    .wbeat_i     (wbeat),
    .cnt_start_o (cnt_start),
    .cnt_step_o  (cnt_step),
    .last_i      (cnt_last),
    .rd_start_o  (rd_start),
    .r_take_o    (r_take)
  );

  beat_counter #(
    .LINE_WORDS (LINE_WORDS)
  ) u_beat_counter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (cnt_start),
    .line_i  (line_i),
    .step_i  (cnt_step),
    .beat_o  (beat),
    .last_o  (cnt_last)
  );

  line_buffer #(
    .LINE_WORDS (LINE_WORDS)
  ) u_line_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wdata_i      (wdata_i),
    .be_i         (be_i),
    .beat_i       (beat),
    .wbeat_o      (wbeat),
    .rd_start_i   (rd_start),
    .line_i       (line_i),
    .offset_i     (addr_i[WORD_OFFSET_LSB +: IDX_W]),
    .r_i          (axi_rsp_i.r),
    .r_take_i     (r_take),
    .line_o       (rdata_o),
    .id_o         (rid),
    .crit_o       (crit_o),
    .crit_valid_o (crit_valid_o)
  );

  // reads report the captured r id, writes the b id
  assign id_o = id_sel ? rid : bid;

endmodule

//--- tb_axi_adapter.sv
// testbench for the cache-to-bus adapter, runs a test table against a stalling bus memory model
`timescale 1ns/1ns

module tb_axi_adapter;
  import axi_adapter_pkg::*;

  localparam int unsigned LINE_WORDS = 4;
  localparam int IDX_W   = $clog2(LINE_WORDS);
  localparam int BYTE_W  = $clog2(STRB_WIDTH);
  localparam int N_TESTS = 10;
  localparam int T_W     = $clog2(N_TESTS);
  // each entry gets 300 cycles, plus the reset and idle check
  localparam int LIMIT   = 300 * N_TESTS + 20;
  localparam addr_t LINE_MASK = ~addr_t'(LINE_WORDS * 8 - 1);

  typedef struct packed {
    logic                   we;
    logic                   line;
    addr_t                  addr;
    id_t                    id;
    word_t [LINE_WORDS-1:0] wdata;
    strb_t [LINE_WORDS-1:0] be;
  } test_t;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   req_i;
  logic                   we_i;
  logic                   line_i;
  addr_t                  addr_i;
  size_t                  size_i;
  id_t                    id_i;
  word_t [LINE_WORDS-1:0] wdata_i;
  strb_t [LINE_WORDS-1:0] be_i;
  logic                   gnt_o;
  logic                   busy_o;
  logic                   valid_o;
  word_t [LINE_WORDS-1:0] rdata_o;
  id_t                    id_o;
  word_t                  crit_o;
  logic                   crit_valid_o;
  axi_req_t               axi_req;
  axi_rsp_t               axi_rsp = '0;

  test_t  tests [N_TESTS];
  word_t  shadow [64];
  word_t  mem [64];
  int     errs = 0;
  int     n_pass = 0;
  int     cycles = 0;
  integer seed = 4555;

  // burst shape of the entry in progress, checked by the bus model
  logic  cur_line = 1'b0;
  addr_t cur_addr = '0;
  id_t   cur_id = '0;

  always #50 clk_i = ~clk_i;

  axi_adapter_top #(
    .LINE_WORDS (LINE_WORDS)
  ) u_axi_adapter_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .we_i         (we_i),
    .line_i       (line_i),
    .addr_i       (addr_i),
    .size_i       (size_i),
    .id_i         (id_i),
    .wdata_i      (wdata_i),
    .be_i         (be_i),
    .gnt_o        (gnt_o),
    .busy_o       (busy_o),
    .valid_o      (valid_o),
    .rdata_o      (rdata_o),
    .id_o         (id_o),
    .crit_o       (crit_o),
    .crit_valid_o (crit_valid_o),
    .axi_req_o    (axi_req),
    .axi_rsp_i    (axi_rsp)
  );

  // --------------------
  // helpers
  // --------------------
  function automatic logic [5:0] word_idx(input addr_t a);
    return a[8:3];
  endfunction

  // initial memory contents, every word differs
  function automatic word_t fill_word(input int i);
    return {32'(i) ^ 32'h5a5a_0000, ~32'(i)};
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t data, input strb_t strb);
    word_t mask;
    mask = '0;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (strb[BYTE_W'(b)]) begin
        mask = mask | (word_t'(8'hff) << (8 * b));
      end
    end
    return (old & ~mask) | (data & mask);
  endfunction

  task automatic value_error(input string msg);
    $display("ERROR %0t: %s", $time, msg);
    errs++;
  endtask

  task automatic set_test(input int idx, input logic we, input logic line, input addr_t addr,
                          input id_t id, input word_t base, input strb_t be);
    test_t e;
    e.we   = we;
    e.line = line;
    e.addr = addr;
    e.id   = id;
    for (int k = 0; k < LINE_WORDS; k++) begin
      e.wdata[IDX_W'(k)] = base + 64'(k) * 64'h0101_0101_0101_0101;
      e.be[IDX_W'(k)]    = be;
    end
    tests[T_W'(idx)] = e;
  endtask

  // aw and ar must carry the line-aligned address and full length for line transfers
  task automatic check_burst(input string ch, input aw_chan_t a);
    if (a.addr != (cur_line ? (cur_addr & LINE_MASK) : cur_addr)) begin
      value_error($sformatf("%s addr got %h", ch, a.addr));
    end
    if (a.len != (cur_line ? 8'(LINE_WORDS - 1) : 8'd0)) begin
      value_error($sformatf("%s len got %0d", ch, a.len));
    end
    if (a.size != 3'd3) begin
      value_error($sformatf("%s size got %0d expected 3", ch, a.size));
    end
    if (a.id != cur_id) begin
      value_error($sformatf("%s id got %0d expected %0d", ch, a.id, cur_id));
    end
  endtask

  // --------------------
  // bus memory model
  // --------------------
  aw_chan_t aw_q;
  ar_chan_t ar_q;
  logic     aw_done;
  logic     w_done;
  logic     b_pend;
  logic     r_act;
  int       w_cnt;
  int       r_cnt;
  word_t    w_data [LINE_WORDS];
  strb_t    w_strb [LINE_WORDS];

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      axi_rsp <= '0;
      aw_done = 1'b0;
      w_done  = 1'b0;
      b_pend  = 1'b0;
      r_act   = 1'b0;
      w_cnt   = 0;
      r_cnt   = 0;
      for (int i = 0; i < 64; i++) begin
        mem[6'(i)] = fill_word(i);
      end
    end else begin
      if (axi_req.aw_valid && axi_rsp.aw_ready) begin
        check_burst("aw", axi_req.aw);
        aw_q    = axi_req.aw;
        aw_done = 1'b1;
      end
      if (axi_req.w_valid && axi_rsp.w_ready) begin
        if (axi_req.w.last != (w_cnt == (cur_line ? LINE_WORDS - 1 : 0))) begin
          value_error($sformatf("w last %0d on beat %0d", axi_req.w.last, w_cnt));
        end
        if (w_cnt < int'(LINE_WORDS)) begin
          w_data[IDX_W'(w_cnt)] = axi_req.w.data;
          w_strb[IDX_W'(w_cnt)] = axi_req.w.strb;
        end
        w_done = axi_req.w.last;
        w_cnt  = w_cnt + 1;
      end
      // commit the burst once address and all data are in
      if (aw_done && w_done) begin
        if (w_cnt != int'(aw_q.len) + 1) begin
          value_error($sformatf("got %0d w beats for len %0d", w_cnt, aw_q.len));
        end
        for (int k = 0; k < w_cnt && k < int'(LINE_WORDS); k++) begin
          mem[word_idx(aw_q.addr) + 6'(k)] = merge_bytes(mem[word_idx(aw_q.addr) + 6'(k)],
                                                         w_data[IDX_W'(k)], w_strb[IDX_W'(k)]);
        end
        aw_done = 1'b0;
        w_done  = 1'b0;
        w_cnt   = 0;
        b_pend  = 1'b1;
      end
      if (axi_req.b_ready && axi_rsp.b_valid) begin
        axi_rsp.b_valid <= 1'b0;
      end else if (b_pend && (($random(seed) & 3) != 0)) begin
        axi_rsp.b_valid <= 1'b1;
        axi_rsp.b.id    <= aw_q.id;
        b_pend = 1'b0;
      end

      if (axi_req.ar_valid && axi_rsp.ar_ready) begin
        check_burst("ar", axi_req.ar);
        ar_q  = axi_req.ar;
        r_act = 1'b1;
        r_cnt = 0;
      end
      if (axi_req.r_ready && axi_rsp.r_valid) begin
        axi_rsp.r_valid <= 1'b0;
        r_cnt = r_cnt + 1;
        if (r_cnt > int'(ar_q.len)) begin
          r_act = 1'b0;
        end
      end else if (r_act && (($random(seed) & 3) != 0)) begin
        axi_rsp.r_valid <= 1'b1;
        axi_rsp.r.data  <= mem[word_idx(ar_q.addr) + 6'(r_cnt)];
        axi_rsp.r.id    <= ar_q.id;
        axi_rsp.r.last  <= (r_cnt == int'(ar_q.len));
      end

      // ready stalls on roughly one cycle in four
      axi_rsp.aw_ready <= ($random(seed) & 3) != 0;
      axi_rsp.w_ready  <= ($random(seed) & 3) != 0;
      axi_rsp.ar_ready <= ($random(seed) & 3) != 0;
    end
  end

  // --------------------
  // tests
  // --------------------
  task automatic update_shadow(input test_t e);
    logic [5:0] base;
    base = word_idx(e.line ? (e.addr & LINE_MASK) : e.addr);
    for (int k = 0; k < (e.line ? LINE_WORDS : 1); k++) begin
      shadow[base + 6'(k)] = merge_bytes(shadow[base + 6'(k)], e.wdata[IDX_W'(k)],
                                         e.be[IDX_W'(k)]);
    end
  endtask

  task automatic check_read(input test_t e, input int crit_n, input word_t crit_word);
    logic [5:0] base;
    base = word_idx(e.line ? (e.addr & LINE_MASK) : e.addr);
    for (int k = 0; k < (e.line ? LINE_WORDS : 1); k++) begin
      if (rdata_o[IDX_W'(k)] != shadow[base + 6'(k)]) begin
        value_error($sformatf("rdata word %0d got %h expected %h", k, rdata_o[IDX_W'(k)],
                              shadow[base + 6'(k)]));
      end
    end
    if (e.line && crit_n != 1) begin
      value_error($sformatf("crit_valid_o pulsed %0d times", crit_n));
    end else if (e.line && crit_word != shadow[word_idx(e.addr)]) begin
      value_error($sformatf("crit_o got %h expected %h", crit_word, shadow[word_idx(e.addr)]));
    end else if (!e.line && crit_n != 0) begin
      value_error("crit_valid_o pulsed on a single read");
    end
  endtask

  task automatic run_test(input int t);
    test_t e;
    int    gnt_n;
    int    crit_n;
    int    errs_before;
    word_t crit_word;
    logic  done;
    e           = tests[T_W'(t)];
    errs_before = errs;
    gnt_n       = 0;
    crit_n      = 0;
    crit_word   = '0;
    done        = 1'b0;
    @(posedge clk_i);
    cur_line <= e.line;
    cur_addr <= e.addr;
    cur_id   <= e.id;
    req_i    <= 1'b1;
    we_i     <= e.we;
    line_i   <= e.line;
    addr_i   <= e.addr;
    size_i   <= 3'd3;
    id_i     <= e.id;
    wdata_i  <= e.wdata;
    be_i     <= e.be;
    while (!done) begin
      @(posedge clk_i);
      if (gnt_o) begin
        gnt_n++;
        req_i <= 1'b0;
      end
      if (crit_valid_o) begin
        crit_n++;
        crit_word = crit_o;
      end
      if (valid_o) begin
        done = 1'b1;
        if (gnt_n != 1) begin
          value_error($sformatf("saw %0d grants before completion", gnt_n));
        end
        if (!busy_o) begin
          value_error("busy_o low at completion");
        end
        if (id_o != e.id) begin
          value_error($sformatf("id_o got %0d expected %0d", id_o, e.id));
        end
        if (e.we) begin
          update_shadow(e);
        end else begin
          check_read(e, crit_n, crit_word);
        end
      end
    end
    @(posedge clk_i);
    if (gnt_o || valid_o || busy_o) begin
      value_error("extra grant, completion or busy after the transaction");
    end
    @(negedge clk_i);
    if (errs == errs_before) begin
      n_pass++;
    end
    $display("test %0d %s%s addr %h id %0d %s", t, e.we ? "write" : "read",
             e.line ? " line" : "", e.addr, e.id, (errs == errs_before) ? "pass" : "FAIL");
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    rst_ni  <= 1'b0;
    req_i   <= 1'b0;
    we_i    <= 1'b0;
    line_i  <= 1'b0;
    addr_i  <= '0;
    size_i  <= 3'd3;
    id_i    <= '0;
    wdata_i <= '0;
    be_i    <= '0;
    for (int i = 0; i < 64; i++) begin
      shadow[6'(i)] = fill_word(i);
    end
    // write, line flag, address, id, first data word, strobes
    set_test(0, 1'b1, 1'b0, 32'h040, 4'd1, 64'h1111_2222_3333_4444, 8'hff);
    set_test(1, 1'b0, 1'b0, 32'h040, 4'd2, '0, '0);
    set_test(2, 1'b1, 1'b1, 32'h080, 4'd3, 64'ha0a0_0000_0000_0001, 8'hff);
    set_test(3, 1'b0, 1'b1, 32'h090, 4'd4, '0, '0);
    set_test(4, 1'b1, 1'b0, 32'h088, 4'd5, 64'hdead_beef_0bad_f00d, 8'h0f);
    set_test(5, 1'b0, 1'b1, 32'h098, 4'd6, '0, '0);
    set_test(6, 1'b0, 1'b0, 32'h100, 4'd7, '0, '0);
    set_test(7, 1'b1, 1'b1, 32'h1d0, 4'd8, 64'h7777_0000_1234_5678, 8'hff);
    set_test(8, 1'b0, 1'b1, 32'h1c8, 4'd9, '0, '0);
    set_test(9, 1'b0, 1'b0, 32'h1d8, 4'd10, '0, '0);
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    // no activity before the first request
    repeat (4) begin
      @(posedge clk_i);
      if (busy_o || gnt_o || valid_o || crit_valid_o || axi_req.aw_valid ||
          axi_req.w_valid || axi_req.ar_valid || axi_req.b_ready || axi_req.r_ready) begin
        value_error("adapter not idle after reset");
      end
    end
    for (int t = 0; t < N_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d passed, %0d errors", N_TESTS, n_pass, errs);
    if (errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- project.f
axi_adapter_pkg.sv
beat_counter.sv
line_buffer.sv
adapter_fsm.sv
axi_adapter_top.sv
tb_axi_adapter.sv

//--- Makefile
# Verilator build and run of the adapter testbench

TOP := tb_axi_adapter

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check for the pass message"
	@echo "  clean  remove the obj_dir build folder"

test:
	verilator --binary --timescale 1ns/1ns --top-module $(TOP) -f project.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir
